// File: src/txd_pkg.sv
package txd_pkg;

	// APB register word offsets
	typedef enum logic [3:0] {
		CTRL   = 4'h0,
		TDBAL  = 4'h1,
		TDBAH  = 4'h2,
		TDLEN  = 4'h3,
		TDH    = 4'h4,
		TDT    = 4'h5,
		TIDV   = 4'h6,
		TADV   = 4'h7,
		THRESH = 4'h8,
		ICR    = 4'h9,
		IMS    = 4'hA
	} reg_addr_e;

	// Bit 31 of the first DMA command beat
	typedef enum logic {
		DMA_READ  = 1'b0,
		DMA_WRITE = 1'b1
	} dma_op_e;

	typedef enum logic [2:0] {
		FETCH_IDLE, FETCH_READY, FETCH_SIZE, FETCH_CMD0,
		FETCH_CMD1, FETCH_CMD2, FETCH_ACK, FETCH_UPDATE
	} fetch_state_e;

	typedef enum logic [2:0] {
		DISP_IDLE, DISP_READY, DISP_CMD, DISP_WAIT, DISP_DONE
	} disp_state_e;

	// Interrupt cause bit positions
	localparam int unsigned ICR_TXDW    = 0;
	localparam int unsigned ICR_TXQE    = 1;
	localparam int unsigned ICR_TXD_LOW = 15;

endpackage

// File: src/txd_regs.sv
`timescale 1ns/1ns

module txd_regs (
	input  logic        aclk,
	input  logic        aresetn,
	input  logic [3:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        enable,
	output logic        dpp,
	output logic [63:0] tdba,
	output logic [15:0] tdlen,
	output logic [15:0] tdt,
	output logic        tdt_set,
	output logic [15:0] tdh_wr,
	output logic        tdh_set,
	output logic [15:0] tidv,
	output logic [15:0] tadv,
	output logic [5:0]  pthresh,
	output logic [5:0]  lwthresh,
	input  logic [15:0] hw_head,
	input  logic        txdw_set,
	input  logic        txqe_set,
	input  logic        txd_low_set,
	output logic        irq
);
	import txd_pkg::*;

	reg_addr_e   addr;
	logic        access;
	logic        mapped;
	logic        wr_en;
	logic        rd_en;
	logic [31:0] rdata;
	logic [31:0] cause;
	logic [31:0] icr;
	logic [31:0] ims;

	assign addr    = reg_addr_e'(paddr);
	assign access  = psel && penable;
	assign wr_en   = access && pwrite && mapped;
	assign rd_en   = access && !pwrite && mapped;
	assign prdata  = rdata;
	// Zero wait states
	assign pready  = 1'b1;
	assign pslverr = access && !mapped;
	assign irq     = |(icr & ims);

	// Read mux and address decode
	always_comb begin
		mapped = 1'b1;
		rdata  = '0;
		case (addr)
			CTRL:    rdata = {30'b0, dpp, enable};
			TDBAL:   rdata = tdba[31:0];
			TDBAH:   rdata = tdba[63:32];
			TDLEN:   rdata = {16'b0, tdlen};
			TDH:     rdata = {16'b0, hw_head};
			TDT:     rdata = {16'b0, tdt};
			TIDV:    rdata = {16'b0, tidv};
			TADV:    rdata = {16'b0, tadv};
			THRESH:  rdata = {18'b0, lwthresh, 2'b0, pthresh};
			ICR:     rdata = icr;
			IMS:     rdata = ims;
			default: mapped = 1'b0;
		endcase
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			enable   <= 1'b0;
			dpp      <= 1'b0;
			tdba     <= '0;
			tdlen    <= '0;
			tdt      <= '0;
			tdt_set  <= 1'b0;
			tdh_set  <= 1'b0;
			tidv     <= '0;
			tadv     <= '0;
			pthresh  <= '0;
			lwthresh <= '0;
			ims      <= '0;
		end else begin
			tdt_set <= 1'b0;
			tdh_set <= 1'b0;
			if (wr_en) begin
				case (addr)
					CTRL: begin
						enable <= pwdata[0];
						dpp    <= pwdata[1];
					end
					TDBAL:  tdba[31:0] <= pwdata;
					TDBAH:  tdba[63:32] <= pwdata;
					TDLEN:  tdlen <= pwdata[15:0];
					TDH:    tdh_set <= 1'b1;
					TDT: begin
						tdt     <= pwdata[15:0];
						tdt_set <= 1'b1;
					end
					TIDV:   tidv <= pwdata[15:0];
					TADV:   tadv <= pwdata[15:0];
					THRESH: begin
						pthresh  <= pwdata[5:0];
						lwthresh <= pwdata[13:8];
					end
					IMS:    ims <= pwdata;
					default: ;
				endcase
			end
		end
	end

	// Head value for the fetch controller, qualified by tdh_set
	always_ff @(posedge aclk) begin
		if (wr_en && addr == TDH)
			tdh_wr <= pwdata[15:0];
	end

	always_comb begin
		cause = '0;
		cause[ICR_TXDW]    = txdw_set;
		cause[ICR_TXQE]    = txqe_set;
		cause[ICR_TXD_LOW] = txd_low_set;
	end

	// New causes win over a clearing read in the same cycle
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			icr <= '0;
		else if (rd_en && addr == ICR)
			icr <= cause;
		else if (wr_en && addr == ICR)
			icr <= (icr & ~pwdata) | cause;
		else
			icr <= icr | cause;
	end

endmodule

// File: src/txd_fetch_ctrl.sv
`timescale 1ns/1ns

module txd_fetch_ctrl #(
	parameter int LOCAL_DEPTH = 16,
	parameter int MAX_BURST = 8
) (
	input  logic                         aclk,
	input  logic                         aresetn,
	input  logic                         enable,
	input  logic                         dpp,
	input  logic [63:0]                  tdba,
	input  logic [15:0]                  tdlen,
	input  logic [15:0]                  tdt,
	input  logic                         tdt_set,
	input  logic [15:0]                  tdh_wr,
	input  logic                         tdh_set,
	input  logic [5:0]                   pthresh,
	input  logic [5:0]                   lwthresh,
	output logic [15:0]                  hw_head,
	output logic [31:0]                  dma_cmd_data,
	output logic                         dma_cmd_valid,
	output logic                         dma_cmd_last,
	input  logic                         dma_cmd_ready,
	input  logic                         dma_rsp_valid,
	input  logic                         dma_rsp_last,
	output logic                         dma_rsp_ready,
	input  logic [$clog2(LOCAL_DEPTH):0] in_count,
	input  logic [$clog2(LOCAL_DEPTH):0] free_slots,
	input  logic                         done_valid,
	input  logic                         done_rs,
	input  logic                         done_ide,
	output logic                         enq_pulse,
	output logic [$clog2(LOCAL_DEPTH):0] enq_count,
	output logic                         deq_pulse,
	output logic                         wb_report,
	output logic                         wb_ide,
	output logic                         txqe_set,
	output logic                         txd_low_set
);
	import txd_pkg::*;

	localparam int AW = $clog2(LOCAL_DEPTH);
	localparam int CW = AW + 1;

	fetch_state_e  state;
	fetch_state_e  state_next;
	logic [15:0]   host_tail;
	logic [15:0]   fetch_ptr;
	logic [15:0]   fetch_end;
	logic [AW-1:0] loc_in_tail;
	logic [AW-1:0] loc_out_head;
	logic [CW-1:0] fetch_num;
	logic          retire;
	logic          retire_rs;
	logic          retire_ide;
	logic          fetch_req;
	logic [15:0]   unfetched;
	logic [15:0]   to_wrap;
	logic [15:0]   head_next;
	logic [15:0]   count_after;
	logic [15:0]   size_cand;
	dma_op_e       op;
	logic [11:0]   cmd_bytes;
	logic [15:0]   local_addr;
	logic [63:0]   host_addr;

	// Descriptors from b up to a on a ring of len entries
	function automatic logic [15:0] ring_dist(input logic [15:0] a, input logic [15:0] b,
			input logic [15:0] len);
		ring_dist = (a >= b) ? a - b : a + len - b;
	endfunction

	assign unfetched   = ring_dist(host_tail, fetch_ptr, tdlen);
	assign to_wrap     = tdlen - fetch_ptr;
	assign head_next   = (hw_head + 16'd1 == tdlen) ? 16'd0 : hw_head + 16'd1;
	assign count_after = ring_dist(host_tail, head_next, tdlen);
	assign fetch_end   = fetch_ptr + 16'(fetch_num);
	assign fetch_req   = enable && unfetched != 16'd0 && free_slots != '0 &&
		(16'(in_count) < 16'(pthresh) || (dpp && in_count == '0));

	// Fetch size is the smallest of the four limits
	always_comb begin
		size_cand = unfetched;
		if (16'(free_slots) < size_cand)
			size_cand = 16'(free_slots);
		if (16'(MAX_BURST) < size_cand)
			size_cand = 16'(MAX_BURST);
		if (to_wrap < size_cand)
			size_cand = to_wrap;
		if (dpp)
			size_cand = 16'd1;
	end

	// Write-backs are checked first
	always_comb begin
		state_next = state;
		case (state)
			FETCH_IDLE:
				if (enable)
					state_next = FETCH_READY;
			FETCH_READY: begin
				if (!enable)
					state_next = FETCH_IDLE;
				else if (done_valid)
					state_next = done_rs ? FETCH_CMD0 : FETCH_UPDATE;
				else if (fetch_req)
					state_next = FETCH_SIZE;
			end
			FETCH_SIZE: state_next = FETCH_CMD0;
			FETCH_CMD0:
				if (dma_cmd_ready)
					state_next = FETCH_CMD1;
			FETCH_CMD1:
				if (dma_cmd_ready)
					state_next = FETCH_CMD2;
			FETCH_CMD2:
				if (dma_cmd_ready)
					state_next = FETCH_ACK;
			FETCH_ACK:
				if (dma_rsp_valid && dma_rsp_last)
					state_next = FETCH_UPDATE;
			default: state_next = FETCH_READY;
		endcase
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state       <= FETCH_IDLE;
			retire      <= 1'b0;
			retire_rs   <= 1'b0;
			retire_ide  <= 1'b0;
			fetch_num   <= '0;
			txqe_set    <= 1'b0;
			txd_low_set <= 1'b0;
		end else begin
			state <= state_next;
			if (state == FETCH_READY) begin
				retire     <= done_valid;
				retire_rs  <= done_rs;
				retire_ide <= done_ide;
			end
			if (state == FETCH_SIZE)
				fetch_num <= CW'(size_cand);
			// Judged on the host count after the head moves
			txqe_set    <= deq_pulse && count_after == 16'd0;
			txd_low_set <= deq_pulse && count_after < {10'b0, lwthresh};
		end
	end

	// Host ring and local slot pointers
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			hw_head      <= '0;
			fetch_ptr    <= '0;
			host_tail    <= '0;
			loc_in_tail  <= '0;
			loc_out_head <= '0;
		end else begin
			if (tdt_set)
				host_tail <= tdt;
			if (tdh_set) begin
				hw_head   <= tdh_wr;
				fetch_ptr <= tdh_wr;
			end else if (deq_pulse) begin
				hw_head      <= head_next;
				loc_out_head <= loc_out_head + 1'b1;
			end else if (enq_pulse) begin
				fetch_ptr   <= (fetch_end == tdlen) ? 16'd0 : fetch_end;
				loc_in_tail <= loc_in_tail + AW'(fetch_num);
			end
		end
	end

	assign enq_pulse     = state == FETCH_UPDATE && !retire;
	assign enq_count     = fetch_num;
	assign deq_pulse     = state == FETCH_UPDATE && retire;
	assign wb_report     = deq_pulse && retire_rs;
	assign wb_ide        = retire_ide;
	assign dma_cmd_valid = state inside {FETCH_CMD0, FETCH_CMD1, FETCH_CMD2};
	assign dma_cmd_last  = state == FETCH_CMD2;
	assign dma_rsp_ready = state == FETCH_ACK;

	// Write-back touches only the status byte at offset 12
	always_comb begin
		if (retire) begin
			op         = DMA_WRITE;
			cmd_bytes  = 12'd1;
			local_addr = 16'({loc_out_head, 4'hC});
			host_addr  = tdba + {44'b0, hw_head, 4'hC};
		end else begin
			op         = DMA_READ;
			cmd_bytes  = 12'({fetch_num, 4'h0});
			local_addr = 16'({loc_in_tail, 4'h0});
			host_addr  = tdba + {44'b0, fetch_ptr, 4'h0};
		end
		case (state)
			FETCH_CMD0: dma_cmd_data = {op, 3'b000, cmd_bytes, local_addr};
			FETCH_CMD1: dma_cmd_data = host_addr[31:0];
			default:    dma_cmd_data = host_addr[63:32];
		endcase
	end

endmodule

// File: src/txd_local_queue.sv
`timescale 1ns/1ns

module txd_local_queue #(
	parameter int LOCAL_DEPTH = 16
) (
	input  logic                         aclk,
	input  logic                         aresetn,
	input  logic                         enable,
	input  logic                         enq_pulse,
	input  logic [$clog2(LOCAL_DEPTH):0] enq_count,
	input  logic                         deq_pulse,
	output logic [$clog2(LOCAL_DEPTH):0] in_count,
	output logic [$clog2(LOCAL_DEPTH):0] free_slots,
	output logic                         done_valid,
	output logic                         done_rs,
	output logic                         done_ide,
	output logic [31:0]                  eng_cmd_data,
	output logic                         eng_cmd_valid,
	input  logic                         eng_cmd_ready,
	input  logic [31:0]                  eng_rsp_data,
	input  logic                         eng_rsp_valid,
	output logic                         eng_rsp_ready
);
	import txd_pkg::*;

	localparam int AW = $clog2(LOCAL_DEPTH);
	localparam int CW = AW + 1;

	disp_state_e   state;
	disp_state_e   state_next;
	logic [AW-1:0] in_head;
	logic [AW-1:0] out_tail;
	logic [AW-1:0] out_head;
	logic [CW-1:0] out_count;
	logic [CW-1:0] used;
	logic [CW-1:0] enq_add;
	logic          disp_deq;
	logic          rsp_take;
	// IDE in bit 1 and RS in bit 0
	logic [1:0]    flag_mem [LOCAL_DEPTH];

	assign enq_add  = enq_pulse ? enq_count : '0;
	assign disp_deq = state == DISP_CMD && eng_cmd_ready;
	assign rsp_take = state == DISP_WAIT && eng_rsp_valid;

	// One descriptor at a time toward the engine
	always_comb begin
		state_next = state;
		case (state)
			DISP_IDLE:
				if (enable)
					state_next = DISP_READY;
			DISP_READY: begin
				if (!enable)
					state_next = DISP_IDLE;
				else if (in_count != '0)
					state_next = DISP_CMD;
			end
			DISP_CMD:
				if (eng_cmd_ready)
					state_next = DISP_WAIT;
			DISP_WAIT:
				if (eng_rsp_valid)
					state_next = DISP_DONE;
			default: state_next = DISP_READY;
		endcase
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state     <= DISP_IDLE;
			in_head   <= '0;
			out_tail  <= '0;
			out_head  <= '0;
			in_count  <= '0;
			out_count <= '0;
			used      <= '0;
		end else begin
			state    <= state_next;
			in_count <= in_count + enq_add - CW'(disp_deq);
			// Slots stay occupied until the fetch controller retires them
			used     <= used + enq_add - CW'(deq_pulse);
			out_count <= out_count + CW'(state == DISP_DONE) - CW'(deq_pulse);
			if (disp_deq)
				in_head <= in_head + 1'b1;
			if (state == DISP_DONE)
				out_tail <= out_tail + 1'b1;
			if (deq_pulse)
				out_head <= out_head + 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (rsp_take)
			flag_mem[out_tail] <= eng_rsp_data[17:16];
	end

	assign free_slots    = CW'(LOCAL_DEPTH) - used;
	assign done_valid    = out_count != '0;
	assign done_rs       = flag_mem[out_head][0];
	assign done_ide      = flag_mem[out_head][1];
	assign eng_cmd_data  = {16'b0, 16'({in_head, 4'h0})};
	assign eng_cmd_valid = state == DISP_CMD;
	assign eng_rsp_ready = state == DISP_WAIT;

endmodule

// File: src/txd_irq_timer.sv
`timescale 1ns/1ns

module txd_irq_timer #(
	parameter int TICK_CYCLES = 4
) (
	input  logic        aclk,
	input  logic        aresetn,
	input  logic [15:0] tidv,
	input  logic [15:0] tadv,
	input  logic        wb_report,
	input  logic        wb_ide,
	output logic        txdw_set
);

	localparam int TW = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

	logic [TW-1:0] presc;
	logic          tick;
	logic [15:0]   delay_timer;
	logic [15:0]   abs_timer;
	logic          wb_delayed;
	logic          fire;

	assign tick       = presc == TW'(TICK_CYCLES - 1);
	assign wb_delayed = wb_report && wb_ide;
	// Zero delay behaves like an immediate write-back
	assign fire = (wb_report && (!wb_ide || tidv == 16'd0)) ||
		(tick && delay_timer == 16'd1) || (tick && abs_timer == 16'd1);

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			presc <= '0;
		else if (tick)
			presc <= '0;
		else
			presc <= presc + 1'b1;
	end

	// Delay timer restarts on every delayed write-back
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			delay_timer <= '0;
		else if (wb_delayed)
			delay_timer <= tidv;
		else if (fire)
			delay_timer <= '0;
		else if (tick && delay_timer != 16'd0)
			delay_timer <= delay_timer - 16'd1;
	end

	// Absolute timer starts only on the first write-back since the last interrupt
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			abs_timer <= '0;
		else if (wb_delayed && abs_timer == 16'd0)
			abs_timer <= tadv;
		else if (fire)
			abs_timer <= '0;
		else if (tick && abs_timer != 16'd0)
			abs_timer <= abs_timer - 16'd1;
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			txdw_set <= 1'b0;
		else
			txdw_set <= fire;
	end

endmodule

// File: src/txd_top.sv
`timescale 1ns/1ns

module txd_top #(
	parameter int LOCAL_DEPTH = 16,
	parameter int MAX_BURST = 8,
	parameter int TICK_CYCLES = 4
) (
	input  logic        aclk,
	input  logic        aresetn,
	input  logic [3:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        irq,
	output logic [31:0] dma_cmd_data,
	output logic        dma_cmd_valid,
	output logic        dma_cmd_last,
	input  logic        dma_cmd_ready,
	input  logic        dma_rsp_valid,
	input  logic        dma_rsp_last,
	output logic        dma_rsp_ready,
	output logic [31:0] eng_cmd_data,
	output logic        eng_cmd_valid,
	input  logic        eng_cmd_ready,
	input  logic [31:0] eng_rsp_data,
	input  logic        eng_rsp_valid,
	output logic        eng_rsp_ready
);

	localparam int CW = $clog2(LOCAL_DEPTH) + 1;

	// Configuration from the register block
	logic          enable;
	logic          dpp;
	logic [63:0]   tdba;
	logic [15:0]   tdlen;
	logic [15:0]   tdt;
	logic          tdt_set;
	logic [15:0]   tdh_wr;
	logic          tdh_set;
	logic [15:0]   tidv;
	logic [15:0]   tadv;
	logic [5:0]    pthresh;
	logic [5:0]    lwthresh;
	logic [15:0]   hw_head;

	// Interrupt causes
	logic          txdw_set;
	logic          txqe_set;
	logic          txd_low_set;

	// Local queue handshake
	logic [CW-1:0] in_count;
	logic [CW-1:0] free_slots;
	logic          done_valid;
	logic          done_rs;
	logic          done_ide;
	logic          enq_pulse;
	logic [CW-1:0] enq_count;
	logic          deq_pulse;
	logic          wb_report;
	logic          wb_ide;

	txd_regs u_regs (
		.aclk        (aclk),
		.aresetn     (aresetn),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.enable      (enable),
		.dpp         (dpp),
		.tdba        (tdba),
		.tdlen       (tdlen),
		.tdt         (tdt),
		.tdt_set     (tdt_set),
		.tdh_wr      (tdh_wr),
		.tdh_set     (tdh_set),
		.tidv        (tidv),
		.tadv        (tadv),
		.pthresh     (pthresh),
		.lwthresh    (lwthresh),
		.hw_head     (hw_head),
		.txdw_set    (txdw_set),
		.txqe_set    (txqe_set),
		.txd_low_set (txd_low_set),
		.irq         (irq)
	);

	txd_fetch_ctrl #(
		.LOCAL_DEPTH (LOCAL_DEPTH),
		.MAX_BURST   (MAX_BURST)
	) u_fetch_ctrl (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.enable        (enable),
		.dpp           (dpp),
		.tdba          (tdba),
		.tdlen         (tdlen),
		.tdt           (tdt),
		.tdt_set       (tdt_set),
		.tdh_wr        (tdh_wr),
		.tdh_set       (tdh_set),
		.pthresh       (pthresh),
		.lwthresh      (lwthresh),
		.hw_head       (hw_head),
		.dma_cmd_data  (dma_cmd_data),
		.dma_cmd_valid (dma_cmd_valid),
		.dma_cmd_last  (dma_cmd_last),
		.dma_cmd_ready (dma_cmd_ready),
		.dma_rsp_valid (dma_rsp_valid),
		.dma_rsp_last  (dma_rsp_last),
		.dma_rsp_ready (dma_rsp_ready),
		.in_count      (in_count),
		.free_slots    (free_slots),
		.done_valid    (done_valid),
		.done_rs       (done_rs),
		.done_ide      (done_ide),
		.enq_pulse     (enq_pulse),
		.enq_count     (enq_count),
		.deq_pulse     (deq_pulse),
		.wb_report     (wb_report),
		.wb_ide        (wb_ide),
		.txqe_set      (txqe_set),
		.txd_low_set   (txd_low_set)
	);

	txd_local_queue #(
		.LOCAL_DEPTH (LOCAL_DEPTH)
	) u_local_queue (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.enable        (enable),
		.enq_pulse     (enq_pulse),
		.enq_count     (enq_count),
		.deq_pulse     (deq_pulse),
		.in_count      (in_count),
		.free_slots    (free_slots),
		.done_valid    (done_valid),
		.done_rs       (done_rs),
		.done_ide      (done_ide),
		.eng_cmd_data  (eng_cmd_data),
		.eng_cmd_valid (eng_cmd_valid),
		.eng_cmd_ready (eng_cmd_ready),
		.eng_rsp_data  (eng_rsp_data),
		.eng_rsp_valid (eng_rsp_valid),
		.eng_rsp_ready (eng_rsp_ready)
	);

	txd_irq_timer #(
		.TICK_CYCLES (TICK_CYCLES)
	) u_irq_timer (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.tidv      (tidv),
		.tadv      (tadv),
		.wb_report (wb_report),
		.wb_ide    (wb_ide),
		.txdw_set  (txdw_set)
	);

endmodule

// File: tb/txd_assertions.sv
`timescale 1ns/1ns

module txd_assertions (
	input logic        aclk,
	input logic        aresetn,
	input logic [31:0] dma_cmd_data,
	input logic        dma_cmd_valid,
	input logic        dma_cmd_last,
	input logic        dma_cmd_ready,
	input logic        dma_rsp_ready,
	input logic        eng_cmd_valid,
	input logic        eng_cmd_ready,
	input logic        eng_rsp_valid,
	input logic        eng_rsp_ready,
	input logic        irq
);
	import txd_pkg::*;

	logic [1:0] beat;
	logic       outstanding;

	// Beat position within the three-beat DMA command
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			beat <= '0;
		else if (dma_cmd_valid && dma_cmd_ready)
			beat <= dma_cmd_last ? 2'd0 : beat + 2'd1;
	end

	// One descriptor in flight at the engine
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			outstanding <= 1'b0;
		else if (eng_cmd_valid && eng_cmd_ready)
			outstanding <= 1'b1;
		else if (eng_rsp_valid && eng_rsp_ready)
			outstanding <= 1'b0;
	end

	cmd_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		dma_cmd_valid && !dma_cmd_ready |=> dma_cmd_valid && $stable(dma_cmd_data))
		else $error("DMA command changed while ready was low");

	last_on_third: assert property (@(posedge aclk) disable iff (!aresetn)
		dma_cmd_valid |-> (dma_cmd_last == (beat == 2'd2)))
		else $error("DMA last flag not on the third beat");

	wb_one_byte: assert property (@(posedge aclk) disable iff (!aresetn)
		dma_cmd_valid && beat == 2'd0 && dma_op_e'(dma_cmd_data[31]) == DMA_WRITE
		|-> dma_cmd_data[27:16] == 12'd1)
		else $error("Write-back command with a byte count other than one");

	single_outstanding: assert property (@(posedge aclk) disable iff (!aresetn)
		outstanding |-> !eng_cmd_valid)
		else $error("Engine command issued while a descriptor is outstanding");

	quiet_in_reset: assert property (@(posedge aclk)
		!aresetn |-> !dma_cmd_valid && !dma_rsp_ready && !eng_cmd_valid && !eng_rsp_ready && !irq)
		else $error("Control output high during reset");

endmodule

bind txd_top txd_assertions u_txd_assertions (
	.aclk          (aclk),
	.aresetn       (aresetn),
	.dma_cmd_data  (dma_cmd_data),
	.dma_cmd_valid (dma_cmd_valid),
	.dma_cmd_last  (dma_cmd_last),
	.dma_cmd_ready (dma_cmd_ready),
	.dma_rsp_ready (dma_rsp_ready),
	.eng_cmd_valid (eng_cmd_valid),
	.eng_cmd_ready (eng_cmd_ready),
	.eng_rsp_valid (eng_rsp_valid),
	.eng_rsp_ready (eng_rsp_ready),
	.irq           (irq)
);

// File: tb/txd_tb.sv
`timescale 1ns/1ns

module txd_tb;
	import txd_pkg::*;

	localparam int MAX_CASES = 32;
	localparam logic [63:0] TDBA = 64'h0000_0012_3456_7000;

	logic        aclk;
	logic        aresetn;
	logic [3:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        irq;
	logic [31:0] dma_cmd_data;
	logic        dma_cmd_valid;
	logic        dma_cmd_last;
	logic        dma_cmd_ready;
	logic        dma_rsp_valid;
	logic        dma_rsp_last;
	logic        dma_rsp_ready;
	logic [31:0] eng_cmd_data;
	logic        eng_cmd_valid;
	logic        eng_cmd_ready;
	logic [31:0] eng_rsp_data;
	logic        eng_rsp_valid;
	logic        eng_rsp_ready;

	integer       seed;
	int           n_cases;
	int           cur;
	int           cyc;
	// Case table, one entry per line of the case file
	logic [127:0] c_name [MAX_CASES];
	int           c_len [MAX_CASES];
	int           c_start [MAX_CASES];
	int           c_tail [MAX_CASES];
	logic [31:0]  c_rs [MAX_CASES];
	logic [31:0]  c_ide [MAX_CASES];
	int           c_tidv [MAX_CASES];
	int           c_dpp [MAX_CASES];
	int           c_lwth [MAX_CASES];
	logic [31:0]  c_sizes [MAX_CASES];
	int           c_head [MAX_CASES];
	// Model state shared by the DMA and engine models
	int           fetch_slot;
	int           base_slot;
	int           fetch_ptr_m;
	int           fetch_idx;
	int           wb_next;
	int           wb_issued;
	int           wb_done;
	int           last_wb_cyc;
	int           eng_idx;
	int           eng_done;
	int           eng_rs_seen;

	txd_top #(
		.LOCAL_DEPTH (16),
		.MAX_BURST   (8),
		.TICK_CYCLES (4)
	) u_txd_top (.*);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	always @(posedge aclk)
		cyc <= cyc + 1;

	task automatic fail_run(input string msg);
		$display("%0s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			fail_run($sformatf("Mismatch %0s %0s: expected %h actual %h",
				c_name[cur], what, exp, act));
	endtask

	task automatic check_op(input dma_op_e exp, input dma_op_e act);
		if (exp !== act)
			fail_run($sformatf("Mismatch %0s DMA op: expected %0s actual %0s",
				c_name[cur], exp.name(), act.name()));
	endtask

	task automatic check_irq(input string what, input logic exp);
		if (exp !== irq)
			fail_run($sformatf("Mismatch %0s %0s: expected %b actual %b",
				c_name[cur], what, exp, irq));
	endtask

	task automatic check_apb_status(input logic [3:0] addr, input logic exp_err);
		if (pready !== 1'b1)
			fail_run($sformatf("Mismatch %0s pready at offset %h: expected 1 actual %b",
				c_name[cur], addr, pready));
		if (pslverr !== exp_err)
			fail_run($sformatf("Mismatch %0s pslverr at offset %h: expected %b actual %b",
				c_name[cur], addr, exp_err, pslverr));
	endtask

	// One APB transfer, status sampled in the access phase
	task automatic apb_access(input logic [3:0] addr, input logic wr, input logic [31:0] wdata,
			input logic exp_err, output logic [31:0] rdata);
		@(posedge aclk);
		#1;
		paddr   = addr;
		pwrite  = wr;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge aclk);
		#1;
		penable = 1'b1;
		@(negedge aclk);
		rdata = prdata;
		check_apb_status(addr, exp_err);
		@(posedge aclk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input reg_addr_e addr, input logic [31:0] data);
		logic [31:0] rdata;
		apb_access(addr, 1'b1, data, 1'b0, rdata);
	endtask

	task automatic apb_read(input reg_addr_e addr, output logic [31:0] data);
		apb_access(addr, 1'b0, 32'd0, 1'b0, data);
	endtask

	task automatic check_reg(input reg_addr_e addr, input logic [31:0] exp);
		logic [31:0] act;
		apb_read(addr, act);
		if (exp !== act)
			fail_run($sformatf("Mismatch %0s %0s read: expected %h actual %h",
				c_name[cur], addr.name(), exp, act));
	endtask

	// DMA model: random ready stalls, beat checks, one response per command
	initial begin : dma_model
		int          beat;
		int          size;
		int          k;
		logic [1:0]  r;
		logic [31:0] exp0;
		logic [63:0] exp_host;
		dma_op_e     exp_op;
		dma_op_e     act_op;
		logic        more_fetch;
		beat     = 0;
		exp_host = '0;
		wait (aresetn);
		forever begin
			@(posedge aclk);
			#1;
			r = 2'($random(seed));
			dma_cmd_ready = r != 2'd0;
			@(negedge aclk);
			if (dma_cmd_valid && dma_cmd_ready) begin
				if (beat == 0) begin
					act_op     = dma_op_e'(dma_cmd_data[31]);
					more_fetch = ((c_sizes[cur] >> (4 * fetch_idx)) & 32'hF) != 32'd0;
					// Either op is legal only when both kinds of work are waiting
					if (eng_rs_seen <= wb_issued)
						exp_op = DMA_READ;
					else if (!more_fetch)
						exp_op = DMA_WRITE;
					else
						exp_op = act_op;
					check_op(exp_op, act_op);
					if (act_op == DMA_WRITE) begin
						while (!c_rs[cur][wb_next])
							wb_next++;
						k = wb_next;
						wb_next++;
						wb_issued++;
						exp0 = {DMA_WRITE, 3'b000, 12'd1, 16'(((base_slot + k) % 16) * 16 + 12)};
						exp_host = TDBA + 64'(((c_start[cur] + k) % c_len[cur]) * 16 + 12);
					end else begin
						size = int'((c_sizes[cur] >> (4 * fetch_idx)) & 32'hF);
						exp0 = {DMA_READ, 3'b000, 12'(size * 16), 16'(fetch_slot * 16)};
						exp_host = TDBA + 64'(fetch_ptr_m * 16);
						fetch_idx++;
						fetch_slot  = (fetch_slot + size) % 16;
						fetch_ptr_m = (fetch_ptr_m + size) % c_len[cur];
					end
					check_word("command beat 1", exp0, dma_cmd_data);
				end else if (beat == 1) begin
					check_word("host address low", exp_host[31:0], dma_cmd_data);
				end else begin
					check_word("host address high", exp_host[63:32], dma_cmd_data);
				end
				check_word("last flag", {31'b0, beat == 2}, {31'b0, dma_cmd_last});
				if (beat == 2) begin
					r = 2'($random(seed));
					repeat (r) @(posedge aclk);
					@(posedge aclk);
					#1;
					dma_cmd_ready = 1'b0;
					dma_rsp_valid = 1'b1;
					dma_rsp_last  = 1'b1;
					@(negedge aclk);
					while (!dma_rsp_ready)
						@(negedge aclk);
					if (act_op == DMA_WRITE) begin
						wb_done++;
						last_wb_cyc = cyc;
					end
					@(posedge aclk);
					#1;
					dma_rsp_valid = 1'b0;
					dma_rsp_last  = 1'b0;
				end
				beat = (beat + 1) % 3;
			end
		end
	end

	// Engine model answers with the RS and IDE bits of the case
	initial begin : engine_model
		int         k;
		logic [1:0] r;
		forever begin
			@(negedge aclk);
			if (eng_cmd_valid && eng_cmd_ready) begin
				check_word("engine slot", 32'(((base_slot + eng_idx) % 16) * 16), eng_cmd_data);
				k = eng_idx;
				eng_idx++;
				r = 2'($random(seed));
				repeat (r) @(posedge aclk);
				@(posedge aclk);
				#1;
				eng_rsp_data  = {14'b0, c_ide[cur][k], c_rs[cur][k], 16'b0};
				eng_rsp_valid = 1'b1;
				@(negedge aclk);
				while (!eng_rsp_ready)
					@(negedge aclk);
				if (c_rs[cur][k])
					eng_rs_seen++;
				eng_done++;
				@(posedge aclk);
				#1;
				eng_rsp_valid = 1'b0;
			end
		end
	end

	initial begin : watchdog
		wait (n_cases > 0);
		repeat (n_cases * 2000) @(posedge aclk);
		fail_run("Watchdog timeout: the test cases did not finish in time");
	end

	initial begin : main
		int           fd;
		int           rc;
		int           i;
		int           k;
		int           count;
		int           n_rs;
		int           n_fetch;
		logic         delayed;
		logic [31:0]  rd;
		logic [31:0]  exp_icr;
		logic [1023:0] line;
		seed          = 32'h25ca_96b7;
		aresetn       = 1'b0;
		paddr         = '0;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		pwdata        = '0;
		dma_cmd_ready = 1'b0;
		dma_rsp_valid = 1'b0;
		dma_rsp_last  = 1'b0;
		eng_cmd_ready = 1'b1;
		eng_rsp_data  = '0;
		eng_rsp_valid = 1'b0;
		cyc = 0;
		cur = 0;
		n_cases = 0;
		fetch_slot = 0;
		base_slot = 0;
		fetch_ptr_m = 0;
		fetch_idx = 0;
		wb_next = 0;
		wb_issued = 0;
		wb_done = 0;
		last_wb_cyc = 0;
		eng_idx = 0;
		eng_done = 0;
		eng_rs_seen = 0;

		fd = $fopen("tb/txd_cases.txt", "r");
		if (fd == 0)
			fail_run("Cannot open the case file tb/txd_cases.txt");
		rc = $fgets(line, fd);
		i = 0;
		while (!$feof(fd) && i < MAX_CASES) begin
			rc = $fscanf(fd, "%s %d %d %d %h %h %d %d %d %h %d", c_name[i], c_len[i],
				c_start[i], c_tail[i], c_rs[i], c_ide[i], c_tidv[i], c_dpp[i], c_lwth[i],
				c_sizes[i], c_head[i]);
			if (rc != 11)
				break;
			i++;
		end
		$fclose(fd);
		if (i == 0)
			fail_run("The case file holds no test case");

		repeat (5) @(posedge aclk);
		#1;
		aresetn = 1'b1;
		n_cases = i;
		apb_write(TDBAL, TDBA[31:0]);
		apb_write(TDBAH, TDBA[63:32]);
		// Offsets past IMS are not decoded
		apb_access(4'hF, 1'b0, 32'd0, 1'b1, rd);

		for (cur = 0; cur < n_cases; cur++) begin
			count = (c_tail[cur] - c_start[cur] + c_len[cur]) % c_len[cur];
			n_rs = 0;
			for (k = 0; k < count; k++)
				n_rs += int'(c_rs[cur][k]);
			n_fetch = 0;
			while (((c_sizes[cur] >> (4 * n_fetch)) & 32'hF) != 32'd0)
				n_fetch++;
			delayed = (c_ide[cur] & c_rs[cur]) != 32'd0 && c_tidv[cur] != 0;
			base_slot = fetch_slot;
			fetch_ptr_m = c_start[cur];
			fetch_idx = 0;
			wb_next = 0;
			wb_issued = 0;
			wb_done = 0;
			eng_idx = 0;
			eng_done = 0;
			eng_rs_seen = 0;

			// Ring setup with the controller disabled
			apb_write(CTRL, 32'd0);
			apb_write(TDLEN, 32'(c_len[cur]));
			apb_write(TDH, 32'(c_start[cur]));
			apb_write(TDT, 32'(c_start[cur]));
			apb_write(TIDV, 32'(c_tidv[cur]));
			apb_write(TADV, 32'h0000_FFFF);
			apb_write(THRESH, 32'(16 | (c_lwth[cur] << 8)));
			apb_write(IMS, 32'd1 << ICR_TXDW);
			apb_read(ICR, rd);
			apb_write(CTRL, {30'b0, c_dpp[cur] != 0, 1'b1});
			apb_write(TDT, 32'(c_tail[cur]));

			@(negedge aclk);
			while (eng_done < count || wb_done < n_rs)
				@(negedge aclk);
			if (delayed) begin
				while (cyc < last_wb_cyc + c_tidv[cur] * 4) begin
					check_irq("early delayed irq", 1'b0);
					@(negedge aclk);
				end
				while (!irq && cyc < last_wb_cyc + (c_tidv[cur] + 2) * 4)
					@(negedge aclk);
				check_irq("delayed irq", 1'b1);
			end
			// Last retire and the queue causes follow within a few cycles
			repeat (6) @(negedge aclk);
			check_word("fetch count", 32'(n_fetch), 32'(fetch_idx));
			check_reg(TDH, 32'(c_head[cur]));
			check_irq("irq after drain", n_rs > 0);
			exp_icr = 32'd1 << ICR_TXQE;
			if (c_lwth[cur] > 0)
				exp_icr |= 32'd1 << ICR_TXD_LOW;
			if (n_rs > 0)
				exp_icr |= 32'd1 << ICR_TXDW;
			check_reg(ICR, exp_icr);
			check_irq("irq after ICR read", 1'b0);
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: tb/txd_cases.txt
# name tdlen start tail rs_mask ide_mask tidv dpp lwthresh fetch_sizes(nibbles,first low) head
basic          16  0  5  1f   0    0  0 0 5   5
wrap_split     12  9  4  55   0    0  0 2 43  4
burst_split    16  2 14  fff  0    0  0 0 48  14
no_rs           8  3  7  0    0    0  0 1 4   7
dpp_single     10  8  1  4    0    0  1 0 111 1
delayed        16  5  8  7    7    12 0 0 3   8
delayed_one     6  5  0  1    1    3  0 2 1   0
dpp_wrap        4  2  1  2    0    0  1 3 111 1
long_ring      20 15 10  1234 0    0  0 1 285 10
wrap_exact     16  8  0  81   0    0  0 0 8   0
delayed_many   16  0 12  fff  fff  40 0 4 48  12

// File: txd.f
src/txd_pkg.sv
src/txd_regs.sv
src/txd_fetch_ctrl.sv
src/txd_local_queue.sv
src/txd_irq_timer.sv
src/txd_top.sv
tb/txd_assertions.sv
tb/txd_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the txd testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module txd_tb -f txd.f \
	--Mdir build -o txd_sim
./build/txd_sim
